// ==== Bender.yml ====
package:
  name: rx_meta

export_include_dirs:
  - .

sources:
  - files:
      - rx_meta_pkg.sv
      - ctrl_regs.sv
      - sync_fifo.sv
      - head_upd_detect.sv
      - meta_merge.sv
      - rx_meta_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_rx_meta_checker.sv
      - tb_rx_meta_top.sv

// ==== ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rx_meta_consts.svh"

module ctrl_regs (
    input  wire                     pcie_clk,
    input  wire                     pcie_reset_n,
    input  wire                     ctrl_write,
    input  wire rx_meta_pkg::ctrl_addr_t ctrl_addr,
    input  wire  [31:0]             ctrl_writedata,
    output logic                    disable_pcie,
    output logic                    sw_reset,
    output logic [31:0]             nb_fallback_queues,
    output logic                    enable_rr
);

logic [31:0] ctrl_word_0;
logic [31:0] ctrl_word_3;
logic [31:0] ctrl_word_0_next;
logic        sw_reset_meta;

always_comb begin
    ctrl_word_0_next = ctrl_word_0;
    if (ctrl_write && (ctrl_addr == 2'd0)) begin
        ctrl_word_0_next = ctrl_writedata;
    end
end

// Words 1 and 2 are not implemented here, so writes to them are dropped.
// The reset request is sampled from the next word value so that sw_reset
// follows the write after exactly two flops. Software clears the bit itself.
always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        ctrl_word_0 <= '0;
        ctrl_word_3 <= '0;
        sw_reset_meta <= 1'b0;
        sw_reset <= 1'b0;
    end else begin
        ctrl_word_0 <= ctrl_word_0_next;
        if (ctrl_write && (ctrl_addr == 2'd3)) begin
            ctrl_word_3 <= ctrl_writedata;
        end
        sw_reset_meta <= ctrl_word_0_next[`SW_RESET_BIT];
        sw_reset <= sw_reset_meta;
    end
end

assign disable_pcie = ctrl_word_0[`DISABLE_BIT];
assign nb_fallback_queues = {{(32 - `FALLBACK_WIDTH){1'b0}},
                             ctrl_word_3[`FALLBACK_LSB +: `FALLBACK_WIDTH]};
assign enable_rr = ctrl_word_3[`ENABLE_RR_BIT];

endmodule

`default_nettype wire

// ==== head_upd_detect.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rx_meta_consts.svh"

module head_upd_detect (
    input  wire                          pcie_clk,
    input  wire                          pcie_reset_n,
    input  wire                          mmio_write,
    input  wire  [`MMIO_ADDR_WIDTH-1:0]  mmio_address,
    input  wire  [`MMIO_BE_WIDTH-1:0]    mmio_byteenable,
    input  wire rx_meta_pkg::counter_t   queue_occupancy,
    output logic                         push,
    output rx_meta_pkg::flow_id_t        push_data,
    output rx_meta_pkg::counter_t        ignored_cnt
);

logic [`QUEUE_IDX_WIDTH-1:0] queue_idx;
logic                        head_upd;
logic                        near_full;

assign queue_idx = mmio_address[`QUEUE_ID_LSB +: `QUEUE_IDX_WIDTH];
assign near_full = queue_occupancy > (`HEAD_UPD_QUEUE_LEN - `HEAD_UPD_MARGIN);

// Head pointer is the second register of the queue page.
always_comb begin
    head_upd = 1'b0;
    if (mmio_write && (queue_idx < `MAX_NB_FLOWS)) begin
        head_upd = mmio_byteenable[`REG_BYTES +: `REG_BYTES] == {`REG_BYTES{1'b1}};
    end
end

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        push <= 1'b0;
        ignored_cnt <= '0;
    end else begin
        push <= head_upd && !near_full;
        // Too many pending updates, this one is lost.
        if (head_upd && near_full) begin
            ignored_cnt <= ignored_cnt + 1'b1;
        end
    end
end

always_ff @(posedge pcie_clk) begin
    if (head_upd) begin
        push_data <= queue_idx[`FLOW_IDX_WIDTH-1:0];
    end
end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
rx_meta_pkg.sv
ctrl_regs.sv
sync_fifo.sv
head_upd_detect.sv
meta_merge.sv
rx_meta_top.sv
tb_clk_gen.sv
tb_rx_meta_checker.sv
tb_rx_meta_top.sv

// ==== meta_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rx_meta_consts.svh"

module meta_merge (
    input  wire                         pcie_clk,
    input  wire                         pcie_reset_n,
    input  wire                         sw_reset,
    input  wire                         head_valid,
    input  wire rx_meta_pkg::flow_id_t  head_queue_id,
    output logic                        head_pop,
    input  wire                         in_meta_valid,
    input  wire rx_meta_pkg::flow_id_t  in_meta_queue_id,
    input  wire rx_meta_pkg::pkt_size_t in_meta_size,
    output logic                        in_meta_ready,
    input  wire rx_meta_pkg::counter_t  out_queue_occupancy,
    output logic                        push,
    output logic [`META_WIDTH-1:0]      push_data,
    output rx_meta_pkg::counter_t       head_upd_cnt
);

logic almost_full;
logic merge_head_pkt;
logic meta_accept;

assign almost_full = out_queue_occupancy >= `IN_QUEUE_ALMOST_FULL;

// Head updates win over packet metadata. When both point at the same
// queue they are folded into one entry, saving a slot in the ordering queue.
always_comb begin
    head_pop = 1'b0;
    in_meta_ready = 1'b0;
    merge_head_pkt = 1'b0;

    if (!almost_full) begin
        if (head_valid) begin
            head_pop = 1'b1;
            merge_head_pkt = in_meta_valid && (head_queue_id == in_meta_queue_id);
            in_meta_ready = merge_head_pkt;
        end else begin
            in_meta_ready = in_meta_valid;
        end
    end
end

assign meta_accept = in_meta_valid && in_meta_ready;

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        push <= 1'b0;
    end else begin
        push <= head_pop || meta_accept;
    end
end

// Metadata entry takes over the head entry on a merge.
always_ff @(posedge pcie_clk) begin
    if (meta_accept) begin
        push_data <= {in_meta_queue_id, in_meta_size, 1'b0, merge_head_pkt};
    end else if (head_pop) begin
        push_data <= {head_queue_id, {`PKT_SIZE_WIDTH{1'b0}}, 1'b1, 1'b0};
    end
end

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n || sw_reset) begin
        head_upd_cnt <= '0;
    end else if (head_pop) begin
        head_upd_cnt <= head_upd_cnt + 1'b1;
    end
end

endmodule

`default_nettype wire

// ==== rx_meta_consts.svh ====
`ifndef RX_META_CONSTS_SVH
`define RX_META_CONSTS_SVH

// Packet queue ids and MMIO address decode.
`define FLOW_IDX_WIDTH 6
`define MAX_NB_FLOWS 48
`define QUEUE_ID_LSB 12
`define QUEUE_IDX_WIDTH 8
`define MMIO_ADDR_WIDTH 20
`define MMIO_BE_WIDTH 64
`define REG_BYTES 4

// Queue depths and thresholds.
`define HEAD_UPD_QUEUE_LEN 16
`define HEAD_UPD_MARGIN 4
`define IN_QUEUE_DEPTH 8
`define IN_QUEUE_ALMOST_FULL 5

// Metadata entry is {queue id, size, descriptor_only, needs_dsc}.
`define PKT_SIZE_WIDTH 16
`define META_WIDTH (`FLOW_IDX_WIDTH + `PKT_SIZE_WIDTH + 2)

// Control word 0.
`define DISABLE_BIT 0
`define SW_RESET_BIT 27

// Control word 3.
`define FALLBACK_LSB 0
`define FALLBACK_WIDTH 30
`define ENABLE_RR_BIT 31

`endif

// ==== rx_meta_pkg.sv ====
`default_nettype none

`include "rx_meta_consts.svh"

package rx_meta_pkg;

// Packet queue id.
typedef logic [`FLOW_IDX_WIDTH-1:0] flow_id_t;

// Packet size in bytes.
typedef logic [`PKT_SIZE_WIDTH-1:0] pkt_size_t;

// Statistics counters and queue occupancy.
typedef logic [31:0] counter_t;

// Index of a control word.
typedef logic [1:0] ctrl_addr_t;

endpackage

`default_nettype wire

// ==== rx_meta_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rx_meta_consts.svh"

module rx_meta_top (
    input  wire                          pcie_clk,
    input  wire                          pcie_reset_n,
    input  wire                          mmio_write,
    input  wire  [`MMIO_ADDR_WIDTH-1:0]  mmio_address,
    input  wire  [`MMIO_BE_WIDTH-1:0]    mmio_byteenable,
    input  wire                          ctrl_write,
    input  wire rx_meta_pkg::ctrl_addr_t ctrl_addr,
    input  wire  [31:0]                  ctrl_writedata,
    input  wire                          in_meta_valid,
    input  wire rx_meta_pkg::flow_id_t   in_meta_queue_id,
    input  wire rx_meta_pkg::pkt_size_t  in_meta_size,
    output logic                         in_meta_ready,
    output logic                         out_meta_valid,
    input  wire                          out_meta_ready,
    output rx_meta_pkg::flow_id_t        out_meta_queue_id,
    output rx_meta_pkg::pkt_size_t       out_meta_size,
    output logic                         out_meta_descriptor_only,
    output logic                         out_meta_needs_dsc,
    output logic                         disable_pcie,
    output logic                         sw_reset,
    output logic [31:0]                  nb_fallback_queues,
    output logic                         enable_rr,
    output rx_meta_pkg::counter_t        rx_ignored_head_cnt,
    output rx_meta_pkg::counter_t        rx_pkt_head_upd_cnt
);

import rx_meta_pkg::*;

logic                    head_push;
flow_id_t                head_push_data;
counter_t                head_occupancy;
logic                    head_pop;
logic                    head_pop_valid;
flow_id_t                head_pop_data;
logic                    in_queue_push;
logic [`META_WIDTH-1:0]  in_queue_push_data;
counter_t                in_queue_occupancy;
logic [`META_WIDTH-1:0]  in_queue_pop_data;

assign {out_meta_queue_id, out_meta_size, out_meta_descriptor_only, out_meta_needs_dsc} =
    in_queue_pop_data;

ctrl_regs ctrl_regs_inst (
    .pcie_clk           (pcie_clk),
    .pcie_reset_n       (pcie_reset_n),
    .ctrl_write         (ctrl_write),
    .ctrl_addr          (ctrl_addr),
    .ctrl_writedata     (ctrl_writedata),
    .disable_pcie       (disable_pcie),
    .sw_reset           (sw_reset),
    .nb_fallback_queues (nb_fallback_queues),
    .enable_rr          (enable_rr)
);

head_upd_detect head_upd_detect_inst (
    .pcie_clk        (pcie_clk),
    .pcie_reset_n    (pcie_reset_n),
    .mmio_write      (mmio_write),
    .mmio_address    (mmio_address),
    .mmio_byteenable (mmio_byteenable),
    .queue_occupancy (head_occupancy),
    .push            (head_push),
    .push_data       (head_push_data),
    .ignored_cnt     (rx_ignored_head_cnt)
);

sync_fifo #(
    .WIDTH (`FLOW_IDX_WIDTH),
    .DEPTH (`HEAD_UPD_QUEUE_LEN)
) head_upd_queue (
    .pcie_clk     (pcie_clk),
    .pcie_reset_n (pcie_reset_n),
    .push         (head_push),
    .push_data    (head_push_data),
    .pop          (head_pop),
    .pop_valid    (head_pop_valid),
    .pop_data     (head_pop_data),
    .occupancy    (head_occupancy)
);

meta_merge meta_merge_inst (
    .pcie_clk            (pcie_clk),
    .pcie_reset_n        (pcie_reset_n),
    .sw_reset            (sw_reset),
    .head_valid          (head_pop_valid),
    .head_queue_id       (head_pop_data),
    .head_pop            (head_pop),
    .in_meta_valid       (in_meta_valid),
    .in_meta_queue_id    (in_meta_queue_id),
    .in_meta_size        (in_meta_size),
    .in_meta_ready       (in_meta_ready),
    .out_queue_occupancy (in_queue_occupancy),
    .push                (in_queue_push),
    .push_data           (in_queue_push_data),
    .head_upd_cnt        (rx_pkt_head_upd_cnt)
);

// Output handshake maps straight onto the queue, which only pops when valid.
sync_fifo #(
    .WIDTH (`META_WIDTH),
    .DEPTH (`IN_QUEUE_DEPTH)
) in_queue (
    .pcie_clk     (pcie_clk),
    .pcie_reset_n (pcie_reset_n),
    .push         (in_queue_push),
    .push_data    (in_queue_push_data),
    .pop          (out_meta_ready),
    .pop_valid    (out_meta_valid),
    .pop_data     (in_queue_pop_data),
    .occupancy    (in_queue_occupancy)
);

endmodule

`default_nettype wire

// ==== sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 8
) (
    input  wire                   pcie_clk,
    input  wire                   pcie_reset_n,
    input  wire                   push,
    input  wire  [WIDTH-1:0]      push_data,
    input  wire                   pop,
    output logic                  pop_valid,
    output logic [WIDTH-1:0]      pop_data,
    output rx_meta_pkg::counter_t occupancy
);

import rx_meta_pkg::*;

localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

logic [WIDTH-1:0]     mem [DEPTH];
logic [PTR_WIDTH-1:0] wr_ptr;
logic [PTR_WIDTH-1:0] rd_ptr;
counter_t             count;
logic                 wr_en;
logic                 rd_en;

assign pop_valid = (count != '0);
assign pop_data = mem[rd_ptr];
assign occupancy = count;

// A push into a full buffer is dropped, producers watch the occupancy.
assign wr_en = push && (count != counter_t'(DEPTH));
assign rd_en = pop && pop_valid;

always_ff @(posedge pcie_clk) begin
    if (wr_en) begin
        mem[wr_ptr] <= push_data;
    end
end

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count <= '0;
    end else begin
        if (wr_en) begin
            wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (rd_en) begin
            rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
        case ({wr_en, rd_en})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: count <= count;
        endcase
    end
end

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic pcie_clk,
    output logic pcie_reset_n
);

initial begin
    pcie_clk = 1'b0;
    forever #(PERIOD_NS / 2) pcie_clk = ~pcie_clk;
end

// Reset leaves with the same small skew as the stimulus.
initial begin
    pcie_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge pcie_clk);
    #2;
    pcie_reset_n = 1'b1;
end

endmodule

`default_nettype wire

// ==== tb_rx_meta_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rx_meta_consts.svh"

module tb_rx_meta_checker (
    input wire                         pcie_clk,
    input wire                         pcie_reset_n,
    input wire                         out_meta_valid,
    input wire                         out_meta_ready,
    input wire rx_meta_pkg::flow_id_t  out_meta_queue_id,
    input wire rx_meta_pkg::pkt_size_t out_meta_size,
    input wire                         out_meta_descriptor_only,
    input wire                         out_meta_needs_dsc
);

import rx_meta_pkg::*;

logic [`META_WIDTH-1:0] expected [$];
logic [`META_WIDTH-1:0] observed;
int                     check_count = 0;
int                     error_count = 0;
int                     desc_count = 0;
int                     last_desc_id = -1;
logic                   desc_mode = 1'b0;

function automatic int pending_count();
    return expected.size();
endfunction

task automatic expect_entry(input logic [`META_WIDTH-1:0] entry);
    expected.push_back(entry);
endtask

task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("[FAIL] %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
endtask

// In this mode only descriptor-only entries are counted, in rising id order.
task automatic start_desc_count();
    desc_count = 0;
    last_desc_id = -1;
    desc_mode = 1'b1;
endtask

task automatic stop_desc_count();
    desc_mode = 1'b0;
endtask

// Inputs only change just after the rising edge, so the falling edge sees
// exactly what the next rising edge will transfer.
always @(negedge pcie_clk) begin
    if (pcie_reset_n === 1'b1 && out_meta_valid === 1'b1 && out_meta_ready === 1'b1) begin
        observed = {out_meta_queue_id, out_meta_size, out_meta_descriptor_only,
                    out_meta_needs_dsc};
        if (desc_mode) begin
            check_value("descriptor-only entry fields", observed[`PKT_SIZE_WIDTH+1:0],
                        {{`PKT_SIZE_WIDTH{1'b0}}, 2'b10});
            check_value("descriptor-only id order",
                        int'(out_meta_queue_id) > last_desc_id, 1);
            last_desc_id = out_meta_queue_id;
            desc_count++;
        end else if (expected.size() == 0) begin
            check_count++;
            error_count++;
            $display("Unexpected output entry %0h at %0d ns while none was expected",
                     observed, $time);
        end else begin
            check_value("output entry", observed, expected.pop_front());
        end
    end
end

endmodule

`default_nettype wire

// ==== tb_rx_meta_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rx_meta_consts.svh"

module tb_rx_meta_top;

import rx_meta_pkg::*;

localparam int DRIVE_DELAY = 2;
localparam int HEAD_BURST = 30;
localparam int META_COUNT = 40;
localparam logic [`MMIO_BE_WIDTH-1:0] HEAD_BE = 64'hF0;

wire                         pcie_clk;
wire                         pcie_reset_n;
logic                        mmio_write;
logic [`MMIO_ADDR_WIDTH-1:0] mmio_address;
logic [`MMIO_BE_WIDTH-1:0]   mmio_byteenable;
logic                        ctrl_write;
ctrl_addr_t                  ctrl_addr;
logic [31:0]                 ctrl_writedata;
logic                        in_meta_valid;
flow_id_t                    in_meta_queue_id;
pkt_size_t                   in_meta_size;
logic                        in_meta_ready;
logic                        out_meta_valid;
logic                        out_meta_ready;
flow_id_t                    out_meta_queue_id;
pkt_size_t                   out_meta_size;
logic                        out_meta_descriptor_only;
logic                        out_meta_needs_dsc;
logic                        disable_pcie;
logic                        sw_reset;
logic [31:0]                 nb_fallback_queues;
logic                        enable_rr;
counter_t                    rx_ignored_head_cnt;
counter_t                    rx_pkt_head_upd_cnt;
integer                      seed;
logic                        meta_done;

tb_clk_gen clk_gen (
    .pcie_clk     (pcie_clk),
    .pcie_reset_n (pcie_reset_n)
);

rx_meta_top i_rx_meta_top (.*);

tb_rx_meta_checker out_checker (.*);

// Equal ids fold into one entry; otherwise the head entry leads.
function automatic int expected_entries(input flow_id_t head_id, input flow_id_t meta_id,
                                        input pkt_size_t size,
                                        output logic [`META_WIDTH-1:0] first,
                                        output logic [`META_WIDTH-1:0] second);
    second = '0;
    if (head_id == meta_id) begin
        first = {meta_id, size, 1'b0, 1'b1};
        return 1;
    end
    first = {head_id, {`PKT_SIZE_WIDTH{1'b0}}, 1'b1, 1'b0};
    second = {meta_id, size, 1'b0, 1'b0};
    return 2;
endfunction

task automatic fail_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display("Checks: %0d run, %0d failed", out_checker.check_count, out_checker.error_count);
    $display("TEST FAILED");
    $finish;
endtask

task automatic next_cycle();
    @(posedge pcie_clk);
    #DRIVE_DELAY;
endtask

task automatic ctrl_wr(input ctrl_addr_t addr, input logic [31:0] data);
    ctrl_write = 1'b1;
    ctrl_addr = addr;
    ctrl_writedata = data;
    next_cycle();
    ctrl_write = 1'b0;
endtask

task automatic mmio_wr(input int idx, input logic [`MMIO_BE_WIDTH-1:0] be);
    mmio_write = 1'b1;
    mmio_address = '0;
    mmio_address[`QUEUE_ID_LSB +: `QUEUE_IDX_WIDTH] = idx[`QUEUE_IDX_WIDTH-1:0];
    mmio_byteenable = be;
    next_cycle();
    mmio_write = 1'b0;
endtask

task automatic send_meta(input flow_id_t qid, input pkt_size_t size);
    int wait_cycles;
    wait_cycles = 0;
    in_meta_valid = 1'b1;
    in_meta_queue_id = qid;
    in_meta_size = size;
    @(negedge pcie_clk);
    while (in_meta_ready !== 1'b1) begin
        wait_cycles++;
        if (wait_cycles > 200) fail_timeout("in_meta_ready");
        @(negedge pcie_clk);
    end
    next_cycle();
    in_meta_valid = 1'b0;
endtask

task automatic wait_drained();
    int wait_cycles;
    wait_cycles = 0;
    while (out_checker.pending_count() != 0) begin
        wait_cycles++;
        if (wait_cycles > 200) fail_timeout("expected output entries");
        next_cycle();
    end
endtask

task automatic wait_sw_reset(input logic level);
    int wait_cycles;
    wait_cycles = 0;
    while (sw_reset !== level) begin
        wait_cycles++;
        if (wait_cycles > 10) fail_timeout("sw_reset to change");
        next_cycle();
    end
endtask

// Both queues are empty once the output has been quiet for a while.
task automatic wait_idle();
    int idle;
    int wait_cycles;
    idle = 0;
    wait_cycles = 0;
    while (idle < 8) begin
        wait_cycles++;
        if (wait_cycles > 300) fail_timeout("the output to go idle");
        next_cycle();
        idle = (out_meta_valid === 1'b1) ? 0 : idle + 1;
    end
endtask

initial begin
    int i;
    int k;
    int n;
    int drained;
    int wait_cycles;
    int ready_cycles;
    flow_id_t qid;
    flow_id_t head_id;
    flow_id_t meta_id;
    pkt_size_t size;
    flow_id_t meta_qids [META_COUNT];
    pkt_size_t meta_sizes [META_COUNT];
    logic [`META_WIDTH-1:0] first_entry;
    logic [`META_WIDTH-1:0] second_entry;
    counter_t ign_base;
    counter_t upd_base;
    counter_t ign_after;

    seed = 32'h757d;
    mmio_write = 1'b0;
    mmio_address = '0;
    mmio_byteenable = '0;
    ctrl_write = 1'b0;
    ctrl_addr = '0;
    ctrl_writedata = '0;
    in_meta_valid = 1'b0;
    in_meta_queue_id = '0;
    in_meta_size = '0;
    out_meta_ready = 1'b1;
    meta_done = 1'b0;

    wait_cycles = 0;
    while (pcie_reset_n !== 1'b1) begin
        wait_cycles++;
        if (wait_cycles > 20) fail_timeout("reset release");
        next_cycle();
    end
    next_cycle();
    out_checker.check_value("in_meta_ready after reset", in_meta_ready, 0);
    out_checker.check_value("out_meta_valid after reset", out_meta_valid, 0);
    out_checker.check_value("sw_reset after reset", sw_reset, 0);
    out_checker.check_value("ignored count after reset", rx_ignored_head_cnt, 0);
    out_checker.check_value("head count after reset", rx_pkt_head_upd_cnt, 0);

    // Control words.
    ctrl_wr(2'd3, 32'h8000_0007);
    out_checker.check_value("enable_rr", enable_rr, 1);
    out_checker.check_value("nb_fallback_queues", nb_fallback_queues, 7);
    ctrl_wr(2'd1, 32'hFFFF_FFFF);
    out_checker.check_value("disable_pcie after word 1", disable_pcie, 0);
    out_checker.check_value("enable_rr after word 1", enable_rr, 1);
    out_checker.check_value("nb_fallback_queues after word 1", nb_fallback_queues, 7);
    ctrl_wr(2'd0, (32'd1 << `SW_RESET_BIT) | (32'd1 << `DISABLE_BIT));
    out_checker.check_value("disable_pcie", disable_pcie, 1);
    out_checker.check_value("sw_reset one cycle after write", sw_reset, 0);
    next_cycle();
    out_checker.check_value("sw_reset two cycles after write", sw_reset, 1);
    ctrl_wr(2'd0, 32'd0);
    out_checker.check_value("disable_pcie cleared", disable_pcie, 0);
    out_checker.check_value("sw_reset one cycle after clear", sw_reset, 1);
    next_cycle();
    out_checker.check_value("sw_reset two cycles after clear", sw_reset, 0);

    // Lone head updates, valid and invalid.
    out_checker.expect_entry({6'd5, {`PKT_SIZE_WIDTH{1'b0}}, 1'b1, 1'b0});
    mmio_wr(5, HEAD_BE);
    mmio_wr(`MAX_NB_FLOWS, HEAD_BE);
    mmio_wr(7, 64'h70);
    wait_drained();
    repeat (10) next_cycle();
    out_checker.check_value("head count after lone updates", rx_pkt_head_upd_cnt, 1);

    // Random metadata under random output back-pressure.
    for (i = 0; i < META_COUNT; i++) begin
        meta_qids[i] = flow_id_t'({$random(seed)} % `MAX_NB_FLOWS);
        meta_sizes[i] = pkt_size_t'($random(seed));
    end
    ready_cycles = 0;
    fork
        begin
            for (i = 0; i < META_COUNT; i++) begin
                out_checker.expect_entry({meta_qids[i], meta_sizes[i], 1'b0, 1'b0});
                send_meta(meta_qids[i], meta_sizes[i]);
            end
            meta_done = 1'b1;
        end
        begin
            while (!meta_done) begin
                ready_cycles++;
                if (ready_cycles > 2000) fail_timeout("the random metadata to be sent");
                out_meta_ready = $random(seed);
                next_cycle();
            end
        end
    join
    out_meta_ready = 1'b1;
    wait_drained();

    // Merge with the ordering queue blocked, equal ids first.
    for (k = 0; k < 2; k++) begin
        out_meta_ready = 1'b0;
        for (i = 0; i < 6; i++) begin
            qid = flow_id_t'({$random(seed)} % `MAX_NB_FLOWS);
            size = pkt_size_t'($random(seed));
            out_checker.expect_entry({qid, size, 1'b0, 1'b0});
            send_meta(qid, size);
        end
        head_id = flow_id_t'(10 + k);
        meta_id = (k == 0) ? head_id : flow_id_t'(20);
        size = pkt_size_t'($random(seed));
        upd_base = rx_pkt_head_upd_cnt;
        mmio_wr(head_id, HEAD_BE);
        repeat (3) next_cycle();
        out_checker.check_value("head update held while blocked", rx_pkt_head_upd_cnt, upd_base);
        n = expected_entries(head_id, meta_id, size, first_entry, second_entry);
        out_checker.expect_entry(first_entry);
        if (n == 2) out_checker.expect_entry(second_entry);
        fork
            send_meta(meta_id, size);
            begin
                repeat (3) next_cycle();
                out_meta_ready = 1'b1;
            end
        join
        wait_drained();
    end

    // Head update burst into a blocked output.
    out_meta_ready = 1'b0;
    ign_base = rx_ignored_head_cnt;
    upd_base = rx_pkt_head_upd_cnt;
    out_checker.start_desc_count();
    for (i = 0; i < HEAD_BURST; i++) begin
        mmio_wr(i, HEAD_BE);
    end
    repeat (2) next_cycle();
    out_meta_ready = 1'b1;
    wait_idle();
    drained = out_checker.desc_count;
    out_checker.stop_desc_count();
    out_checker.check_value("updates were dropped", rx_ignored_head_cnt > ign_base, 1);
    out_checker.check_value("ignored plus drained", rx_ignored_head_cnt - ign_base + drained,
                            HEAD_BURST);
    out_checker.check_value("head count matches drained", rx_pkt_head_upd_cnt - upd_base,
                            drained);
    ign_after = rx_ignored_head_cnt;
    ctrl_wr(2'd0, 32'd1 << `SW_RESET_BIT);
    wait_sw_reset(1'b1);
    next_cycle();
    out_checker.check_value("head count after sw_reset", rx_pkt_head_upd_cnt, 0);
    out_checker.check_value("ignored count after sw_reset", rx_ignored_head_cnt, ign_after);
    ctrl_wr(2'd0, 32'd0);
    wait_sw_reset(1'b0);

    $display("Checks: %0d run, %0d failed", out_checker.check_count, out_checker.error_count);
    if (out_checker.error_count == 0) begin
        $display("TEST PASSED");
    end else begin
        $display("TEST FAILED");
    end
    $finish;
end

endmodule

`default_nettype wire
